//--- design/pmp_pkg.sv
// Shared widths, CSR numbers and structs of the PMP subsystem.
// Every PMP module imports this package.
package pmp_pkg;

   // ------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------
   localparam int PMP_ENTRIES    = 16;
   // Four cfg bytes per pmpcfg CSR
   localparam int PMP_CFG_GROUPS = PMP_ENTRIES / 4;

   typedef logic [11:0] csr_num_t;
   typedef logic [31:0] xlen_t;
   // Bits 29:0 hold word address bits 31:2, bits 31:30 read as zero
   typedef logic [31:0] pmp_addr_t;
   typedef logic [29:0] word_addr_t;
   typedef logic [3:0]  entry_idx_t;
   // AXI byte address, CSR number sits in bits 13:2
   typedef logic [13:0] axi_addr_t;
   typedef logic [1:0]  axi_resp_t;

   // Address matching modes
   typedef logic [1:0] pmp_mode_t;
   localparam pmp_mode_t MODE_OFF   = 2'd0;
   localparam pmp_mode_t MODE_TOR   = 2'd1;
   localparam pmp_mode_t MODE_NA4   = 2'd2;
   localparam pmp_mode_t MODE_NAPOT = 2'd3;

   // One cfg byte, bit 7 down to bit 0
   typedef struct packed {
      logic      lock;
      logic [1:0] rsvd;
      pmp_mode_t mode;
      logic      exec;
      logic      write;
      logic      read;
   } pmp_cfg_t;

   localparam csr_num_t CSR_PMPCFG_BASE  = 12'h3a0;
   localparam csr_num_t CSR_PMPADDR_BASE = 12'h3b0;

   // Access types on the check port
   typedef logic [1:0] acc_t;
   localparam acc_t ACC_READ  = 2'd0;
   localparam acc_t ACC_WRITE = 2'd1;
   localparam acc_t ACC_EXEC  = 2'd2;

   typedef struct packed {
      word_addr_t addr;
      acc_t       acc;
      logic       machine;
   } check_req_t;

   typedef struct packed {
      logic       allowed;
      logic       hit;
      entry_idx_t entry;
   } check_resp_t;

   // Register access from the bus control to the register block
   typedef struct packed {
      logic       we;
      logic       cfg_sel;
      logic       addr_sel;
      entry_idx_t idx;
   } csr_access_t;

   typedef enum logic [1:0] {
      IDLE,
      WRITE_RESP,
      READ_RESP
   } axil_state_e;

   localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
   localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

endpackage

//--- design/pmp_axil_ctl.sv
// AXI4-Lite slave front end of the PMP register block.
// Decodes CSR numbers from the bus address and sequences the handshakes.
module pmp_axil_ctl (
   input  logic                clk,
   input  logic                reset,
   // Write address and data channels
   input  logic                awvalid,
   input  pmp_pkg::axi_addr_t  awaddr,
   output logic                awready,
   input  logic                wvalid,
   input  pmp_pkg::xlen_t      wdata,
   // CSR writes are whole-word, strobes carry no meaning here
   input  logic [3:0]          wstrb,
   output logic                wready,
   // Write response channel
   output logic                bvalid,
   output pmp_pkg::axi_resp_t  bresp,
   input  logic                bready,
   // Read channels
   input  logic                arvalid,
   input  pmp_pkg::axi_addr_t  araddr,
   output logic                arready,
   output logic                rvalid,
   output pmp_pkg::xlen_t      rdata,
   output pmp_pkg::axi_resp_t  rresp,
   input  logic                rready,
   // Register block side
   output pmp_pkg::csr_access_t csr_access,
   output pmp_pkg::xlen_t      csr_wdata,
   input  pmp_pkg::xlen_t      csr_rdata
);
   import pmp_pkg::*;

   axil_state_e state;
   csr_num_t    sel_csr;
   logic        write_go;
   logic        read_go;
   logic        sel_cfg;
   logic        sel_addr;
   logic        sel_mapped;

   // ------------------------------------------------------------
   // Request acceptance
   // ------------------------------------------------------------
   // Write needs both address and data, and wins over a read
   assign write_go = (state == IDLE) & awvalid & wvalid;
   assign read_go  = (state == IDLE) & arvalid & ~(awvalid & wvalid);

   assign awready = write_go;
   assign wready  = write_go;
   assign arready = read_go;

   // CSR number comes from the channel being served
   assign sel_csr = write_go ? awaddr[13:2] : araddr[13:2];

   // pmpcfg0..3 and pmpaddr0..15
   assign sel_cfg    = (sel_csr[11:2] == CSR_PMPCFG_BASE[11:2]);
   assign sel_addr   = (sel_csr[11:4] == CSR_PMPADDR_BASE[11:4]);
   assign sel_mapped = sel_cfg | sel_addr;

   // Unmapped writes never reach the registers
   assign csr_access.we       = write_go & sel_mapped;
   assign csr_access.cfg_sel  = sel_cfg;
   assign csr_access.addr_sel = sel_addr;
   assign csr_access.idx      = sel_csr[3:0];
   assign csr_wdata           = wdata;

   // ------------------------------------------------------------
   // Handshake FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (write_go) begin
                  state <= WRITE_RESP;
               end else if (read_go) begin
                  state <= READ_RESP;
               end
            end
            // Hold the response until the master takes it
            WRITE_RESP: begin
               if (bready) begin
                  state <= IDLE;
               end
            end
            READ_RESP: begin
               if (rready) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign bvalid = (state == WRITE_RESP);
   assign rvalid = (state == READ_RESP);

   // Response payload, captured at the accepting edge
   always_ff @(posedge clk) begin
      if (write_go) begin
         bresp <= sel_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end
      if (read_go) begin
         // Unmapped reads return zero data
         rdata <= sel_mapped ? csr_rdata : '0;
         rresp <= sel_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end
   end

endmodule

//--- design/pmp_csr_regs.sv
// pmpcfg and pmpaddr storage with WARL masking and entry locks.
// Written and read through the csr_access select from the bus control.
module pmp_csr_regs (
   input  logic                 clk,
   input  logic                 reset,
   input  pmp_pkg::csr_access_t csr_access,
   input  pmp_pkg::xlen_t       csr_wdata,
   output pmp_pkg::xlen_t       csr_rdata,
   output pmp_pkg::pmp_cfg_t    pmp_cfg  [pmp_pkg::PMP_ENTRIES],
   output pmp_pkg::pmp_addr_t   pmp_addr [pmp_pkg::PMP_ENTRIES]
);
   import pmp_pkg::*;

   // Writes that hit a cfg group or an address entry
   logic cfg_wr;
   logic addr_wr;

   assign cfg_wr  = csr_access.we & csr_access.cfg_sel;
   assign addr_wr = csr_access.we & csr_access.addr_sel;

   // ------------------------------------------------------------
   // Per-entry storage
   // ------------------------------------------------------------
   for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_entry
      pmp_cfg_t   cfg_q;
      pmp_cfg_t   raw_cfg;
      pmp_cfg_t   warl_cfg;
      word_addr_t addr_q;
      logic       next_tor_lock;
      logic       cfg_we;
      logic       addr_we;

      // Byte lane of this entry within its group
      assign raw_cfg = pmp_cfg_t'(csr_wdata[(i % 4) * 8 +: 8]);

      // Reserved bits read as zero
      // W without R is not a legal combination, so W drops
      always_comb begin
         warl_cfg      = raw_cfg;
         warl_cfg.rsvd = 2'b00;
         if (!raw_cfg.read) begin
            warl_cfg.write = 1'b0;
         end
      end

      // Address is also frozen by a locked TOR entry just above
      if (i < PMP_ENTRIES - 1) begin : g_next
         assign next_tor_lock = pmp_cfg[i + 1].lock & (pmp_cfg[i + 1].mode == MODE_TOR);
      end else begin : g_last
         assign next_tor_lock = 1'b0;
      end

      assign cfg_we  = cfg_wr & (csr_access.idx == entry_idx_t'(i / 4)) & ~cfg_q.lock;
      assign addr_we = addr_wr & (csr_access.idx == entry_idx_t'(i)) &
                       ~(cfg_q.lock | next_tor_lock);

      // All entries come up OFF and unlocked
      always_ff @(posedge clk) begin
         if (reset) begin
            cfg_q  <= '0;
            addr_q <= '0;
         end else begin
            if (cfg_we) begin
               cfg_q <= warl_cfg;
            end
            if (addr_we) begin
               addr_q <= csr_wdata[29:0];
            end
         end
      end

      assign pmp_cfg[i]  = cfg_q;
      // Only 32-bit physical space, top two bits stay zero
      assign pmp_addr[i] = {2'b00, addr_q};
   end

   // ------------------------------------------------------------
   // Read mux
   // ------------------------------------------------------------
   always_comb begin
      csr_rdata = '0;
      if (csr_access.cfg_sel) begin
         // Entry 4*g+b lands in byte b
         for (int b = 0; b < 4; b++) begin
            csr_rdata[b * 8 +: 8] = pmp_cfg[{csr_access.idx[1:0], 2'(b)}];
         end
      end else if (csr_access.addr_sel) begin
         csr_rdata = pmp_addr[csr_access.idx];
      end
   end

endmodule

//--- design/pmp_region_match.sv
// Address range matching for every PMP entry.
// Purely combinational, one match bit per entry.
module pmp_region_match (
   input  pmp_pkg::check_req_t         check_req,
   input  pmp_pkg::pmp_cfg_t           pmp_cfg  [pmp_pkg::PMP_ENTRIES],
   input  pmp_pkg::pmp_addr_t          pmp_addr [pmp_pkg::PMP_ENTRIES],
   output logic [pmp_pkg::PMP_ENTRIES-1:0] match_vec
);
   import pmp_pkg::*;

   word_addr_t req_addr;

   assign req_addr = check_req.addr;

   for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_match
      word_addr_t hi_addr;
      word_addr_t lo_addr;
      word_addr_t napot_mask;
      logic       tor_hit;
      logic       na4_hit;
      logic       napot_hit;

      assign hi_addr = pmp_addr[i][29:0];

      // Bottom of a TOR range is the previous entry address
      if (i == 0) begin : g_first
         assign lo_addr = '0;
      end else begin : g_rest
         assign lo_addr = pmp_addr[i - 1][29:0];
      end

      // ------------------------------------------------------------
      // Mode comparators
      // ------------------------------------------------------------
      // Range [lo, hi), empty when lo >= hi
      assign tor_hit = (req_addr >= lo_addr) & (req_addr < hi_addr);

      // Single word
      assign na4_hit = (req_addr == hi_addr);

      // Trailing ones of pmpaddr plus the zero above them
      // e.g. yyy0111 gives a mask of 0001111
      assign napot_mask = hi_addr ^ (hi_addr + word_addr_t'(1));
      assign napot_hit  = ((req_addr ^ hi_addr) & ~napot_mask) == '0;

      always_comb begin
         case (pmp_cfg[i].mode)
            MODE_TOR:   match_vec[i] = tor_hit;
            MODE_NA4:   match_vec[i] = na4_hit;
            MODE_NAPOT: match_vec[i] = napot_hit;
            // OFF never matches
            default:    match_vec[i] = 1'b0;
         endcase
      end
   end

endmodule

//--- design/pmp_check.sv
// Permission decision for a checked access.
// Lowest matching entry wins, result registered one cycle later.
module pmp_check (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          check_valid,
   input  pmp_pkg::check_req_t           check_req,
   input  logic [pmp_pkg::PMP_ENTRIES-1:0] match_vec,
   input  pmp_pkg::pmp_cfg_t             pmp_cfg [pmp_pkg::PMP_ENTRIES],
   output logic                          resp_valid,
   output pmp_pkg::check_resp_t          resp
);
   import pmp_pkg::*;

   logic       hit;
   entry_idx_t hit_idx;
   pmp_cfg_t   hit_cfg;
   logic       perm;
   logic       allowed;

   // ------------------------------------------------------------
   // Priority encoder
   // ------------------------------------------------------------
   // Scan downwards so the lowest match is written last
   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
         if (match_vec[i]) begin
            hit     = 1'b1;
            hit_idx = entry_idx_t'(i);
         end
      end
   end

   assign hit_cfg = pmp_cfg[hit_idx];

   // Permission bit for the access type, unknown types get none
   always_comb begin
      case (check_req.acc)
         ACC_READ:  perm = hit_cfg.read;
         ACC_WRITE: perm = hit_cfg.write;
         ACC_EXEC:  perm = hit_cfg.exec;
         default:   perm = 1'b0;
      endcase
   end

   // Machine mode bypasses unlocked entries
   // No match: machine allowed, user denied
   always_comb begin
      if (hit) begin
         allowed = perm | (check_req.machine & ~hit_cfg.lock);
      end else begin
         allowed = check_req.machine;
      end
   end

   // ------------------------------------------------------------
   // Response register
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= check_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (check_valid) begin
         resp.allowed <= allowed;
         resp.hit     <= hit;
         resp.entry   <= hit_idx;
      end
   end

endmodule

//--- design/pmp_top.sv
// PMP subsystem top: AXI4-Lite CSR port plus a one-cycle check port.
module pmp_top (
   input  logic                 clk,
   input  logic                 reset,
   // AXI4-Lite slave
   input  logic                 awvalid,
   input  pmp_pkg::axi_addr_t   awaddr,
   output logic                 awready,
   input  logic                 wvalid,
   input  pmp_pkg::xlen_t       wdata,
   input  logic [3:0]           wstrb,
   output logic                 wready,
   output logic                 bvalid,
   output pmp_pkg::axi_resp_t   bresp,
   input  logic                 bready,
   input  logic                 arvalid,
   input  pmp_pkg::axi_addr_t   araddr,
   output logic                 arready,
   output logic                 rvalid,
   output pmp_pkg::xlen_t       rdata,
   output pmp_pkg::axi_resp_t   rresp,
   input  logic                 rready,
   // Check port
   input  logic                 check_valid,
   input  pmp_pkg::check_req_t  check_req,
   output logic                 resp_valid,
   output pmp_pkg::check_resp_t resp
);
   import pmp_pkg::*;

   csr_access_t              csr_access;
   xlen_t                    csr_wdata;
   xlen_t                    csr_rdata;
   pmp_cfg_t                 pmp_cfg  [PMP_ENTRIES];
   pmp_addr_t                pmp_addr [PMP_ENTRIES];
   logic [PMP_ENTRIES-1:0]   match_vec;

   // Bus control and CSR decode
   pmp_axil_ctl u_ctl (
      .clk, .reset,
      .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
      .bvalid, .bresp, .bready,
      .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
      .csr_access, .csr_wdata, .csr_rdata
   );

   // Configuration storage
   pmp_csr_regs u_regs (
      .clk, .reset,
      .csr_access, .csr_wdata, .csr_rdata,
      .pmp_cfg, .pmp_addr
   );

   // Entry matching on the incoming request
   pmp_region_match u_match (
      .check_req, .pmp_cfg, .pmp_addr, .match_vec
   );

   // Priority, permission and response register
   pmp_check u_check (
      .clk, .reset,
      .check_valid, .check_req, .match_vec, .pmp_cfg,
      .resp_valid, .resp
   );

endmodule

//--- dv/pmp_tb_sva.sv
// Protocol assertions bound into the PMP top level
// AXI response stability, check-port latency and write channel acceptance
module pmp_tb_sva (
   input logic               clk,
   input logic               reset,
   input logic               awvalid,
   input logic               wvalid,
   input logic               bvalid,
   input logic               bready,
   input pmp_pkg::axi_resp_t bresp,
   input logic               rvalid,
   input logic               rready,
   input pmp_pkg::xlen_t     rdata,
   input pmp_pkg::axi_resp_t rresp,
   input logic               awready,
   input logic               wready,
   input logic               check_valid,
   input logic               resp_valid
);
   // Responses hold until the master accepts them
   assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid or bresp changed before bready");
   assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("rvalid or read payload changed before rready");

   // One cycle of latency on the check port
   assert property (@(posedge clk) disable iff (reset) check_valid |=> resp_valid)
      else $error("resp_valid missing one cycle after check_valid");
   assert property (@(posedge clk) disable iff (reset) !check_valid |=> !resp_valid)
      else $error("resp_valid without a request");

   // Address and data go in together for a single cycle
   // The write response follows in the next cycle
   assert property (@(posedge clk) disable iff (reset)
      awready |-> (wready && awvalid && wvalid) ##1 (!awready && bvalid))
      else $error("awready without wready and both valids, or no write response after it");
endmodule

bind pmp_top pmp_tb_sva u_sva (
   .clk, .reset, .awvalid, .wvalid, .bvalid, .bready, .bresp,
   .rvalid, .rready, .rdata, .rresp,
   .awready, .wready, .check_valid, .resp_valid
);

//--- dv/pmp_tb.sv
// Testbench for the PMP subsystem over its AXI4-Lite CSR port and its check port
// Keeps its own model of the registers and the match rules, and compares every response
module pmp_tb;
   import pmp_pkg::*;

   localparam int N_CHECKS   = 400;
   // Rough operation count and a per-operation cycle bound for the watchdog
   localparam int NUM_OPS    = 200 + N_CHECKS;
   localparam int OP_CYCLES  = 16;

   logic        clk;
   logic        reset;
   logic        awvalid;
   logic        wvalid;
   logic        bready;
   logic        arvalid;
   logic        rready;
   axi_addr_t   awaddr;
   axi_addr_t   araddr;
   xlen_t       wdata;
   logic [3:0]  wstrb;
   logic        awready;
   logic        wready;
   logic        bvalid;
   logic        arready;
   logic        rvalid;
   axi_resp_t   bresp;
   axi_resp_t   rresp;
   xlen_t       rdata;
   logic        check_valid;
   check_req_t  check_req;
   logic        resp_valid;
   check_resp_t resp;

   pmp_cfg_t    m_cfg  [PMP_ENTRIES];
   word_addr_t  m_addr [PMP_ENTRIES];
   check_resp_t exp_q[$];
   logic [15:0] lfsr_q;

   pmp_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog
   initial begin
      #(NUM_OPS * OP_CYCLES * 4);
      $display("Timeout: the run did not finish within the cycle bound");
      $display("Simulation finished: FAIL");
      $fatal(1);
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("FAIL at time %0t: %s", $time, msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   // Galois LFSR stepped once per bit
   function automatic logic lfsr_bit();
      logic b;
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) lfsr_q = lfsr_q ^ 16'hb400;
      return b;
   endfunction

   function automatic xlen_t rand_bits(input int n);
      xlen_t v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   task automatic cmp_data(input xlen_t got, input xlen_t exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s data %h expected %h", what, got, exp));
   endtask

   task automatic cmp_code(input axi_resp_t got, input axi_resp_t exp, input string what);
      if (got !== exp) stop_on_error($sformatf("%s resp %b expected %b", what, got, exp));
   endtask

   task automatic cmp_check(input check_resp_t got, input check_resp_t exp);
      if (got !== exp) stop_on_error($sformatf("check resp %h expected %h", got, exp));
   endtask

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   function automatic logic model_write(input csr_num_t c, input xlen_t d);
      pmp_cfg_t nc;
      int       e;
      logic     locked;
      if (c >= 12'h3a0 && c <= 12'h3a3) begin
         for (int b = 0; b < 4; b++) begin
            e  = int'(c[1:0]) * 4 + b;
            nc = pmp_cfg_t'(d[b * 8 +: 8]);
            nc.rsvd = 2'b00;
            if (!nc.read) nc.write = 1'b0;
            if (!m_cfg[e].lock) m_cfg[e] = nc;
         end
         return 1'b1;
      end else if (c >= 12'h3b0 && c <= 12'h3bf) begin
         e      = int'(c[3:0]);
         locked = m_cfg[e].lock;
         if (e < PMP_ENTRIES - 1 && m_cfg[e + 1].lock && m_cfg[e + 1].mode == MODE_TOR)
            locked = 1'b1;
         if (!locked) m_addr[e] = d[29:0];
         return 1'b1;
      end
      return 1'b0;
   endfunction

   function automatic xlen_t model_read(input csr_num_t c);
      xlen_t v;
      v = '0;
      if (c >= 12'h3a0 && c <= 12'h3a3) begin
         for (int b = 0; b < 4; b++) v[b * 8 +: 8] = m_cfg[int'(c[1:0]) * 4 + b];
      end else if (c >= 12'h3b0 && c <= 12'h3bf) begin
         v = {2'b00, m_addr[c[3:0]]};
      end
      return v;
   endfunction

   function automatic check_resp_t ref_check(input check_req_t q);
      check_resp_t r;
      longint      a;
      longint      hi;
      longint      lo;
      int          t;
      logic        m;
      logic        perm;
      // Default outside every entry
      r = '0;
      r.allowed = q.machine;
      // Highest entry first so the lowest match is the one kept
      for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
         a  = q.addr;
         hi = m_addr[i];
         lo = (i == 0) ? 0 : m_addr[i - 1];
         t  = 0;
         while (t < 30 && hi[t]) t++;
         case (m_cfg[i].mode)
            MODE_TOR:   m = (a >= lo) && (a < hi);
            MODE_NA4:   m = (a == hi);
            MODE_NAPOT: m = ((a >> (t + 1)) == (hi >> (t + 1)));
            default:    m = 1'b0;
         endcase
         if (m) begin
            perm = (q.acc == ACC_READ) ? m_cfg[i].read :
                   (q.acc == ACC_WRITE) ? m_cfg[i].write :
                   (q.acc == ACC_EXEC) ? m_cfg[i].exec : 1'b0;
            r.hit     = 1'b1;
            r.entry   = entry_idx_t'(i);
            // Machine mode needs the permission bit only on a locked entry
            if (q.machine && !m_cfg[i].lock) begin
               r.allowed = 1'b1;
            end else begin
               r.allowed = perm;
            end
         end
      end
      return r;
   endfunction

   // ------------------------------------------------------------
   // AXI driver tasks with a random stall on the response channel
   // ------------------------------------------------------------
   task automatic axi_write(input csr_num_t c, input xlen_t d, output axi_resp_t r);
      int stall;
      @(negedge clk);
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = {c, 2'b00};
      wdata   = d;
      #1;
      while (!(awready && wready)) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      if (!bvalid) stop_on_error("bvalid did not rise after the write handshake");
      r     = bresp;
      stall = int'(rand_bits(2));
      repeat (stall) begin
         @(negedge clk);
         if (!bvalid || bresp !== r) stop_on_error("write response changed while stalled");
      end
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axi_read(input csr_num_t c, output xlen_t d, output axi_resp_t r);
      int stall;
      @(negedge clk);
      arvalid = 1'b1;
      araddr  = {c, 2'b00};
      #1;
      while (!arready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
      if (!rvalid) stop_on_error("rvalid did not rise after the read handshake");
      d     = rdata;
      r     = rresp;
      stall = int'(rand_bits(2));
      repeat (stall) begin
         @(negedge clk);
         if (!rvalid || rdata !== d || rresp !== r)
            stop_on_error("read response changed while stalled");
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic write_csr(input csr_num_t c, input xlen_t d);
      axi_resp_t r;
      logic      mapped;
      mapped = model_write(c, d);
      axi_write(c, d, r);
      cmp_code(r, mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR, $sformatf("write %h", c));
   endtask

   task automatic read_check(input csr_num_t c);
      xlen_t     d;
      axi_resp_t r;
      logic      mapped;
      mapped = (c >= 12'h3a0 && c <= 12'h3a3) || (c >= 12'h3b0 && c <= 12'h3bf);
      axi_read(c, d, r);
      cmp_code(r, mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR, $sformatf("read %h", c));
      cmp_data(d, model_read(c), $sformatf("read %h", c));
   endtask

   task automatic read_all();
      for (int i = 0; i < 4; i++) read_check(csr_num_t'(12'h3a0 + i));
      for (int i = 0; i < PMP_ENTRIES; i++) read_check(csr_num_t'(12'h3b0 + i));
   endtask

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < PMP_ENTRIES; i++) begin
         m_cfg[i]  = '0;
         m_addr[i] = '0;
      end
   endtask

   // Compare process for the check port
   always @(negedge clk) begin
      if (!reset && resp_valid) begin
         if (exp_q.size() == 0) stop_on_error("check response with no request outstanding");
         cmp_check(resp, exp_q.pop_front());
      end
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      check_req_t q;
      int         wait_cycles;
      lfsr_q  = 16'd38;
      reset   = 1'b1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      rready  = 1'b0;
      awaddr  = '0;
      araddr  = '0;
      wdata   = '0;
      wstrb   = 4'hf;
      check_valid = 1'b0;
      check_req   = '0;
      apply_reset();

      // Random write and read back with every lock bit kept clear
      for (int i = 0; i < PMP_ENTRIES; i++) begin
         write_csr(csr_num_t'(12'h3b0 + i), rand_bits(32));
         read_check(csr_num_t'(12'h3b0 + i));
      end
      for (int i = 0; i < 4; i++) begin
         write_csr(csr_num_t'(12'h3a0 + i), rand_bits(32) & 32'h7f7f7f7f);
         read_check(csr_num_t'(12'h3a0 + i));
      end

      // Lock entry 2, then lock entry 5 in TOR mode to freeze pmpaddr4
      write_csr(12'h3a0, 32'h00830000);
      write_csr(12'h3a1, 32'h00008b00);
      write_csr(12'h3a0, 32'h07070707);
      write_csr(12'h3b2, 32'h12345678);
      write_csr(12'h3b4, 32'h0badcafe);
      write_csr(12'h3b5, 32'h00000055);
      read_all();

      // Unmapped CSR numbers
      write_csr(12'h3a4, 32'hffffffff);
      write_csr(12'h3c0, 32'hffffffff);
      write_csr(12'h000, 32'hffffffff);
      read_check(12'h3a4);
      read_check(12'h3af);
      read_check(12'hfff);
      read_all();

      // Random configuration in a small address window so entries overlap
      apply_reset();
      for (int i = 0; i < PMP_ENTRIES; i++) write_csr(csr_num_t'(12'h3b0 + i), rand_bits(8));
      for (int i = 0; i < 4; i++) write_csr(csr_num_t'(12'h3a0 + i), rand_bits(32));
      read_all();

      // Back-to-back checks
      for (int k = 0; k < N_CHECKS; k++) begin
         @(negedge clk);
         q.addr    = word_addr_t'(rand_bits(8));
         q.acc     = acc_t'(rand_bits(2));
         if (q.acc == 2'd3) q.acc = ACC_READ;
         q.machine = lfsr_bit();
         check_valid = 1'b1;
         check_req   = q;
         exp_q.push_back(ref_check(q));
      end
      @(negedge clk);
      check_valid = 1'b0;
      wait_cycles = 0;
      while (exp_q.size() != 0 && wait_cycles < 4) begin
         @(negedge clk);
         wait_cycles++;
      end

      if (exp_q.size() != 0) begin
         $display("Check responses missing at the end of the run");
         $display("Simulation finished: FAIL");
         $fatal(1);
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

//--- sim.f
design/pmp_pkg.sv
design/pmp_axil_ctl.sv
design/pmp_csr_regs.sv
design/pmp_region_match.sv
design/pmp_check.sv
design/pmp_top.sv
dv/pmp_tb_sva.sv
dv/pmp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the PMP testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module pmp_tb -Mdir obj_dir

out=$(./obj_dir/Vpmp_tb)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
else
   exit 1
fi
